//--- touch_pkg.sv
`default_nettype none

package touch_pkg;

	// Divider and transfer timing
	localparam int SCLK_HALF_PERIOD    = 4;	// cclk cycles per touch_clk half period
	localparam int REPEATS_PER_CHANNEL = 15;	// Conversions per channel, last one kept
	localparam int CMD_BITS            = 8;
	localparam int RESULT_BITS         = 12;
	localparam int TAIL_PERIODS        = 2;	// touch_clk periods with csb high after a transfer

	// Counter widths
	localparam int DIV_CNT_W = $clog2(SCLK_HALF_PERIOD);
	localparam int BIT_CNT_W = $clog2(RESULT_BITS + 1);	// Covers CMD_BITS too
	localparam int REP_CNT_W = $clog2(REPEATS_PER_CHANNEL);

	typedef logic [RESULT_BITS-1:0] sample_t;	// Raw or calibrated converter word
	typedef logic [CMD_BITS-1:0]    cmd_t;	// Command byte
	typedef logic [DIV_CNT_W-1:0]   div_cnt_t;
	typedef logic [BIT_CNT_W-1:0]   bit_cnt_t;
	typedef logic [REP_CNT_W-1:0]   rep_cnt_t;

	// Calibration window
	localparam sample_t X_ADJ_MIN      = 12'h090;
	localparam sample_t X_POST_ADJ_MAX = 12'h745;
	localparam sample_t Y_ADJ_MIN      = 12'h060;
	localparam sample_t Y_POST_ADJ_MAX = 12'h6F0;

	// Channel select field of the command byte
	typedef enum logic [1:0] {
		CH_Y = 2'b00,
		CH_Z = 2'b01,
		CH_X = 2'b10
	} channel_t;

	typedef enum logic [2:0] {IDLE, SEND, GAP, RECV, TAIL} xfer_state_t;

	typedef struct packed {
		channel_t channel;
		sample_t  data;
	} touch_sample_s;	// Finished raw sample

	typedef struct packed {
		sample_t x;
		sample_t y;
		sample_t z;
	} touch_xyz_s;

	// Start bit in 0, channel in 2:1, bit 3 set, upper nibble clear; sent LSB first
	function automatic cmd_t make_cmd(input channel_t ch);
		cmd_t c;
		c      = '0;
		c[0]   = 1'b1;
		c[2:1] = ch;
		c[3]   = 1'b1;
		return c;
	endfunction

endpackage

`default_nettype wire

//--- touch_sclk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module touch_sclk_gen (
	input  wire  cclk,
	input  wire  rstb,
	output logic touch_clk,
	output logic sclk_rise,	// Pulses in the cycle touch_clk goes high
	output logic sclk_fall	// Pulses in the cycle touch_clk goes low
);

	touch_pkg::div_cnt_t div_cnt;
	logic                wrap;

	assign wrap = (div_cnt == touch_pkg::div_cnt_t'(touch_pkg::SCLK_HALF_PERIOD - 1));

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			div_cnt   <= '0;
			touch_clk <= 1'b0;
			sclk_rise <= 1'b0;
			sclk_fall <= 1'b0;
		end else begin
			sclk_rise <= 1'b0;	// Strobes last one cycle
			sclk_fall <= 1'b0;
			if (wrap) begin
				div_cnt   <= '0;
				touch_clk <= ~touch_clk;
				// Edge strobes line up with the new level
				sclk_rise <= ~touch_clk;
				sclk_fall <= touch_clk;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- touch_spi_engine.sv
`timescale 1ns/1ns
`default_nettype none

module touch_spi_engine (
	input  wire                  cclk,
	input  wire                  rstb,
	input  wire                  sclk_rise,
	input  wire                  sclk_fall,
	input  wire                  start,	// Taken only in IDLE
	input  wire touch_pkg::channel_t channel,
	input  wire                  data_in,	// Serial result from the converter
	output logic                 touch_csb,
	output logic                 data_out,	// Serial command to the converter
	output logic                 done,
	output touch_pkg::sample_t   result	// Held until the next done
);

	touch_pkg::xfer_state_t state;
	touch_pkg::bit_cnt_t    bit_cnt;	// Shared by SEND, RECV and TAIL
	touch_pkg::cmd_t        cmd_sr;	// Command shifter with the LSB out first
	touch_pkg::sample_t     rx_sr;	// Result shifter with the MSB in first

	logic load_cmd;
	logic cmd_last;
	logic shift_cmd;
	logic shift_rx;
	logic rx_last;
	logic tail_end;

	// Phase events
	assign load_cmd  = (state == touch_pkg::IDLE) && start;
	assign cmd_last  = (bit_cnt == touch_pkg::bit_cnt_t'(touch_pkg::CMD_BITS));
	assign shift_cmd = (state == touch_pkg::SEND) && sclk_fall && !cmd_last;
	assign shift_rx  = (state == touch_pkg::RECV) && sclk_rise;
	assign rx_last   = (bit_cnt == touch_pkg::bit_cnt_t'(touch_pkg::RESULT_BITS - 1));
	assign tail_end  = (state == touch_pkg::TAIL) && sclk_rise &&
		(bit_cnt == touch_pkg::bit_cnt_t'(touch_pkg::TAIL_PERIODS - 1));

	// Control FSM
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			state     <= touch_pkg::IDLE;
			bit_cnt   <= '0;
			touch_csb <= 1'b1;
			data_out  <= 1'b0;
			done      <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				touch_pkg::IDLE: begin
					if (load_cmd) begin
						bit_cnt <= '0;
						state   <= touch_pkg::SEND;	// Wait for the next fall
					end
				end
				touch_pkg::SEND: begin
					if (sclk_fall) begin
						touch_csb <= 1'b0;
						if (cmd_last) begin	// Byte is out and the line returns to zero
							data_out <= 1'b0;
							bit_cnt  <= '0;
							state    <= touch_pkg::GAP;
						end else begin
							data_out <= cmd_sr[0];
							bit_cnt  <= bit_cnt + 1'b1;
						end
					end
				end
				touch_pkg::GAP: begin
					if (sclk_fall)
						state <= touch_pkg::RECV;	// One idle period done
				end
				touch_pkg::RECV: begin
					if (shift_rx) begin
						if (rx_last) begin
							bit_cnt   <= '0;
							touch_csb <= 1'b1;	// Deselect for the tail
							state     <= touch_pkg::TAIL;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				touch_pkg::TAIL: begin
					if (tail_end) begin
						done    <= 1'b1;
						bit_cnt <= '0;
						state   <= touch_pkg::IDLE;
					end else if (sclk_rise) begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				default: state <= touch_pkg::IDLE;
			endcase
		end
	end

	// Shifters and result register
	always_ff @(posedge cclk) begin
		if (load_cmd)
			cmd_sr <= touch_pkg::make_cmd(channel);	// Channel is stable from here
		else if (shift_cmd)
			cmd_sr <= cmd_sr >> 1;
		if (shift_rx)
			rx_sr <= {rx_sr[touch_pkg::RESULT_BITS-2:0], data_in};
		if (tail_end)
			result <= rx_sr;	// Valid with done
	end

endmodule

`default_nettype wire

//--- touch_channel_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module touch_channel_sequencer (
	input  wire                       cclk,
	input  wire                       rstb,
	input  wire                       done,	// End of one transfer
	input  wire touch_pkg::sample_t   result,
	output logic                      start,
	output touch_pkg::channel_t       channel,	// Held through each transfer
	output logic                      sample_valid,
	output touch_pkg::touch_sample_s  sample
);

	touch_pkg::rep_cnt_t rep_cnt;
	logic                boot;	// Set in reset to kick off the first transfer
	logic                last_rep;

	assign last_rep = (rep_cnt == touch_pkg::rep_cnt_t'(touch_pkg::REPEATS_PER_CHANNEL - 1));

	// Fixed scan order
	function automatic touch_pkg::channel_t next_channel(input touch_pkg::channel_t ch);
		touch_pkg::channel_t nxt;
		case (ch)
			touch_pkg::CH_X: nxt = touch_pkg::CH_Y;
			touch_pkg::CH_Y: nxt = touch_pkg::CH_Z;
			default:         nxt = touch_pkg::CH_X;
		endcase
		return nxt;
	endfunction

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			boot         <= 1'b1;
			start        <= 1'b0;
			rep_cnt      <= '0;
			channel      <= touch_pkg::CH_X;
			sample_valid <= 1'b0;
		end else begin
			boot         <= 1'b0;
			start        <= boot | done;	// Cycle after reset or after done
			sample_valid <= 1'b0;
			if (done) begin
				if (last_rep) begin
					rep_cnt      <= '0;
					sample_valid <= 1'b1;	// Only the last conversion counts
					channel      <= next_channel(channel);
				end else begin
					rep_cnt <= rep_cnt + 1'b1;
				end
			end
		end
	end

	// Sample payload tagged with the channel it came from
	always_ff @(posedge cclk) begin
		if (done && last_rep) begin
			sample.channel <= channel;
			sample.data    <= result;
		end
	end

endmodule

`default_nettype wire

//--- touch_calibrate.sv
`timescale 1ns/1ns
`default_nettype none

module touch_calibrate (
	input  wire                          cclk,
	input  wire                          rstb,
	input  wire                          sample_valid,
	input  wire touch_pkg::touch_sample_s sample,
	output touch_pkg::touch_xyz_s        xyz,	// Held between updates
	output logic                         update
);

	touch_pkg::sample_t x_adj;
	touch_pkg::sample_t y_adj;

	// Remove offset, floor at zero, cap at the usable span
	function automatic touch_pkg::sample_t adjust(
		input touch_pkg::sample_t raw,
		input touch_pkg::sample_t adj_min,
		input touch_pkg::sample_t post_max
	);
		touch_pkg::sample_t diff;
		diff = raw - adj_min;
		if (raw < adj_min)
			return '0;	// Below the panel edge
		else if (diff > post_max)
			return post_max;
		else
			return diff;
	endfunction

	assign x_adj = adjust(sample.data, touch_pkg::X_ADJ_MIN, touch_pkg::X_POST_ADJ_MAX);
	assign y_adj = adjust(sample.data, touch_pkg::Y_ADJ_MIN, touch_pkg::Y_POST_ADJ_MAX);

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			xyz    <= '0;
			update <= 1'b0;
		end else begin
			update <= sample_valid;	// Same cycle as the new field
			if (sample_valid) begin
				case (sample.channel)	// Other fields keep their value
					touch_pkg::CH_X: xyz.x <= x_adj;
					touch_pkg::CH_Y: xyz.y <= y_adj;
					default:         xyz.z <= sample.data;	// z is raw
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- touchpad_controller.sv
`timescale 1ns/1ns
`default_nettype none

module touchpad_controller (
	input  wire                   cclk,
	input  wire                   rstb,
	input  wire                   touch_busy,	// Not used by this controller
	input  wire                   data_in,	// Converter serial output
	output logic                  touch_clk,
	output logic                  data_out,	// Converter serial input
	output logic                  touch_csb,
	output touch_pkg::touch_xyz_s xyz,
	output logic                  update
);

	// Divider strobes
	logic sclk_rise;
	logic sclk_fall;

	// Sequencer and engine strobes
	logic                xfer_start;
	logic                xfer_done;
	touch_pkg::channel_t xfer_channel;
	touch_pkg::sample_t  xfer_result;

	// Last sample of each channel
	logic                     sample_valid;
	touch_pkg::touch_sample_s sample;

	touch_sclk_gen u_sclk_gen (
		.cclk      (cclk),
		.rstb      (rstb),
		.touch_clk (touch_clk),
		.sclk_rise (sclk_rise),
		.sclk_fall (sclk_fall)
	);

	touch_spi_engine u_spi_engine (
		.cclk      (cclk),
		.rstb      (rstb),
		.sclk_rise (sclk_rise),
		.sclk_fall (sclk_fall),
		.start     (xfer_start),
		.channel   (xfer_channel),
		.data_in   (data_in),
		.touch_csb (touch_csb),
		.data_out  (data_out),
		.done      (xfer_done),
		.result    (xfer_result)
	);

	touch_channel_sequencer u_sequencer (
		.cclk         (cclk),
		.rstb         (rstb),
		.done         (xfer_done),
		.result       (xfer_result),
		.start        (xfer_start),
		.channel      (xfer_channel),
		.sample_valid (sample_valid),
		.sample       (sample)
	);

	touch_calibrate u_calibrate (
		.cclk         (cclk),
		.rstb         (rstb),
		.sample_valid (sample_valid),
		.sample       (sample),
		.xyz          (xyz),
		.update       (update)
	);

endmodule

`default_nettype wire

//--- tb_touchpad_model.sv
`timescale 1ns/1ns
`default_nettype none

module tb_touchpad_model (
	input  wire                cclk,
	input  wire                touch_clk,
	input  wire                touch_csb,
	input  wire                data_out,	// Command bits from the DUT
	output wire                data_in,	// Result bits back to the DUT
	output wire                xfer_seen,	// One cclk per decoded command
	output wire                frame_err,	// Frame had the wrong length
	output touch_pkg::cmd_t    cmd,
	output touch_pkg::sample_t result,	// Result sent in this frame
	output wire [31:0]         xfer_count
);

	localparam int FRAME_RISES = touch_pkg::CMD_BITS + 1 + touch_pkg::RESULT_BITS;

	integer             seed = 32'h3dc2e790;
	logic               sclk_q = 1'b0;	// touch_clk at the previous negedge
	int                 rise_cnt = 0;	// Rises seen with csb low in this frame
	touch_pkg::cmd_t    cmd_sr = '0;
	touch_pkg::sample_t tx_sr = '0;	// MSB goes out first
	touch_pkg::sample_t drawn;
	logic               sdo = 1'b0;
	logic               seen_q = 1'b0;
	logic               err_q = 1'b0;
	logic [31:0]        count = '0;

	assign data_in    = sdo;
	assign xfer_seen  = seen_q;
	assign frame_err  = err_q;
	assign xfer_count = count;

	// Random 12-bit word with one draw in four on a calibration edge
	function automatic touch_pkg::sample_t draw_result();
		integer             r;
		touch_pkg::sample_t v;
		r = $random(seed);
		v = r[15:4];
		if (r[1:0] == 2'b00) begin
			case (r[18:16])
				3'd0:    v = '0;
				3'd1:    v = 12'hFFF;
				3'd2:    v = touch_pkg::X_ADJ_MIN - 12'd1;
				3'd3:    v = touch_pkg::X_ADJ_MIN;
				3'd4:    v = touch_pkg::X_ADJ_MIN + 12'd1;
				3'd5:    v = touch_pkg::Y_ADJ_MIN - 12'd1;
				3'd6:    v = touch_pkg::Y_ADJ_MIN;
				default: v = touch_pkg::Y_ADJ_MIN + 12'd1;
			endcase
		end
		return v;
	endfunction

	always @(negedge cclk) begin
		sclk_q <= touch_clk;
		seen_q <= 1'b0;
		err_q  <= 1'b0;
		if (touch_csb) begin
			sdo <= 1'b0;	// Line parked between frames
			if (rise_cnt != 0 && rise_cnt != FRAME_RISES)
				err_q <= 1'b1;
			rise_cnt <= 0;
		end else if (touch_clk && !sclk_q) begin	// Rising touch_clk
			rise_cnt <= rise_cnt + 1;
			if (rise_cnt < touch_pkg::CMD_BITS)
				cmd_sr <= {data_out, cmd_sr[7:1]};	// LSB arrives first
			if (rise_cnt == touch_pkg::CMD_BITS - 1) begin
				drawn = draw_result();
				cmd    <= {data_out, cmd_sr[7:1]};
				result <= drawn;
				tx_sr  <= drawn;
				seen_q <= 1'b1;
				count  <= count + 1'b1;
			end
		end else if (!touch_clk && sclk_q) begin	// Falling touch_clk
			// First result bit follows the idle period
			if (rise_cnt > touch_pkg::CMD_BITS && rise_cnt < FRAME_RISES) begin
				sdo   <= tx_sr[11];
				tx_sr <= {tx_sr[10:0], 1'b0};
			end
		end
	end

endmodule

`default_nettype wire

//--- tb_touchpad_controller.sv
`timescale 1ns/1ns
`default_nettype none

module tb_touchpad_controller;

	localparam int CLK_PERIOD   = 8;
	localparam int ROUNDS       = 3;
	localparam int RUN_UPDATES  = 3 * ROUNDS;	// One update per channel per round
	localparam int RUN_XFERS    = RUN_UPDATES * touch_pkg::REPEATS_PER_CHANNEL;
	localparam int XFER_PERIODS = 25 + touch_pkg::TAIL_PERIODS;
	// Whole run in ns with 50% margin
	localparam int WATCHDOG_NS  = RUN_XFERS * XFER_PERIODS * 2 * touch_pkg::SCLK_HALF_PERIOD *
		CLK_PERIOD * 3 / 2;

	logic                  cclk;
	logic                  rstb;
	logic                  touch_busy;
	wire                   data_in;
	logic                  touch_clk;
	logic                  data_out;
	logic                  touch_csb;
	touch_pkg::touch_xyz_s xyz;
	logic                  update;

	// Model reports
	wire                model_seen;
	wire                model_err;
	touch_pkg::cmd_t    model_cmd;
	touch_pkg::sample_t model_result;
	wire [31:0]         model_count;

	// Reference model state
	int                    errors = 0;
	int                    checks = 0;
	int                    xfers = 0;
	int                    updates = 0;
	touch_pkg::sample_t    last_x = '0;	// Latest raw result per channel
	touch_pkg::sample_t    last_y = '0;
	touch_pkg::sample_t    last_z = '0;
	touch_pkg::touch_xyz_s pred = '0;	// Predicted output set
	touch_pkg::channel_t   ch_now;

	touchpad_controller UUT (
		.cclk       (cclk),
		.rstb       (rstb),
		.touch_busy (touch_busy),
		.data_in    (data_in),
		.touch_clk  (touch_clk),
		.data_out   (data_out),
		.touch_csb  (touch_csb),
		.xyz        (xyz),
		.update     (update)
	);

	tb_touchpad_model u_model (
		.cclk       (cclk),
		.touch_clk  (touch_clk),
		.touch_csb  (touch_csb),
		.data_out   (data_out),
		.data_in    (data_in),
		.xfer_seen  (model_seen),
		.frame_err  (model_err),
		.cmd        (model_cmd),
		.result     (model_result),
		.xfer_count (model_count)
	);

	// Scan order x, y, z by run index
	function automatic touch_pkg::channel_t channel_at(input int run);
		case (run % 3)
			0:       return touch_pkg::CH_X;
			1:       return touch_pkg::CH_Y;
			default: return touch_pkg::CH_Z;
		endcase
	endfunction

	function automatic touch_pkg::cmd_t expected_cmd(input touch_pkg::channel_t ch);
		return {4'b0000, 1'b1, ch, 1'b1};
	endfunction

	// Offset, floor at zero, cap at the post-offset limit
	function automatic touch_pkg::sample_t calib(input touch_pkg::sample_t raw,
		input touch_pkg::sample_t lo, input touch_pkg::sample_t hi);
		int d;
		d = int'(raw) - int'(lo);
		if (d < 0)
			return '0;
		if (d > int'(hi))
			return hi;
		return touch_pkg::sample_t'(d);
	endfunction

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_sample(input string name, input touch_pkg::sample_t exp,
		input touch_pkg::sample_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_cmd(input string name, input touch_pkg::cmd_t exp,
		input touch_pkg::cmd_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_xyz(input string name, input touch_pkg::touch_xyz_s exp,
		input touch_pkg::touch_xyz_s act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s: expected x=%h y=%h z=%h, actual x=%h y=%h z=%h",
				name, exp.x, exp.y, exp.z, act.x, act.y, act.z);
		end
	endtask

	initial begin
		cclk = 1'b0;
		forever #(CLK_PERIOD / 2) cclk = ~cclk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog: the run did not finish %0d updates within %0d ns",
			RUN_UPDATES, WATCHDOG_NS);
		$display("SOME TESTS FAILED");
		$finish;
	end

	// Outputs are stable at the falling edge
	always @(negedge cclk) begin
		if (model_seen) begin
			ch_now = channel_at(xfers / touch_pkg::REPEATS_PER_CHANNEL);
			check_cmd($sformatf("command %0d", xfers), expected_cmd(ch_now), model_cmd);
			case (ch_now)
				touch_pkg::CH_X: last_x = model_result;
				touch_pkg::CH_Y: last_y = model_result;
				default:         last_z = model_result;
			endcase
			xfers++;
		end
		if (model_err) begin
			errors++;
			$display("Transfer %0d had the wrong number of touch_clk periods", xfers);
		end
		if (rstb && update) begin
			ch_now = channel_at(updates);
			if (xfers != (updates + 1) * touch_pkg::REPEATS_PER_CHANNEL) begin
				errors++;
				$display("Update %0d came after %0d transfers instead of %0d", updates, xfers,
					(updates + 1) * touch_pkg::REPEATS_PER_CHANNEL);
			end
			case (ch_now)	// Only the field of this channel moves
				touch_pkg::CH_X: begin
					pred.x = calib(last_x, touch_pkg::X_ADJ_MIN, touch_pkg::X_POST_ADJ_MAX);
					check_sample($sformatf("x at update %0d", updates), pred.x, xyz.x);
				end
				touch_pkg::CH_Y: begin
					pred.y = calib(last_y, touch_pkg::Y_ADJ_MIN, touch_pkg::Y_POST_ADJ_MAX);
					check_sample($sformatf("y at update %0d", updates), pred.y, xyz.y);
				end
				default: begin
					pred.z = last_z;	// Raw
					check_sample($sformatf("z at update %0d", updates), pred.z, xyz.z);
				end
			endcase
			check_xyz($sformatf("xyz at update %0d", updates), pred, xyz);
			updates++;
		end
	end

	initial begin
		rstb       = 1'b0;
		touch_busy = 1'b0;
		repeat (3) @(posedge cclk);	// Reset held for 3 cycles
		@(negedge cclk);
		check_bit("touch_csb after reset", 1'b1, touch_csb);
		check_bit("update after reset", 1'b0, update);
		check_bit("data_out after reset", 1'b0, data_out);
		check_bit("touch_clk after reset", 1'b0, touch_clk);
		check_xyz("xyz after reset", '0, xyz);
		rstb = 1'b1;
		wait (updates == RUN_UPDATES);
		if (model_count != RUN_XFERS) begin
			errors++;
			$display("Model saw %0d transfers in %0d rounds instead of %0d", model_count,
				ROUNDS, RUN_XFERS);
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
touch_pkg.sv
touch_sclk_gen.sv
touch_spi_engine.sv
touch_channel_sequencer.sv
touch_calibrate.sv
touchpad_controller.sv
tb_touchpad_model.sv
tb_touchpad_controller.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_touchpad_controller
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'ALL TESTS PASSED'

clean:
	rm -rf $(OBJ_DIR)
